// File: tb.f
+incdir+verilog
verilog/fe_pkg.sv
verilog/fe_apb_regs.sv
verilog/fe_mult_seq.sv
verilog/fe_mult_pass.sv
verilog/fe_reduce.sv
verilog/fe_mult_top.sv
verif/fe_checker.sv
verif/fe_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the field multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -f tb.f --top-module fe_tb -o fe_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/fe_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TESTS PASSED" "$SIM_LOG"; then
	exit 0
fi
exit 1

// File: verif/fe_tb.sv
`include "fe_consts.svh"

module fe_tb;

	// Field prime 2^255 - 19
	localparam logic [255:0] P = (256'd1 << 255) - 256'd19;
	// Cycles allowed for one product to finish
	localparam int POLL_LIMIT = 2000;

	logic         clk;
	logic         rst_n_i;
	logic         psel;
	logic         penable;
	logic         pwrite;
	logic [7:0]   paddr;
	logic [31:0]  pwdata;
	logic [31:0]  prdata;
	logic         pready;
	logic         pslverr;
	logic         exp_chk;
	logic [31:0]  exp_data;
	logic         exp_err;
	int           chk_errs;
	int           tmo_errs;
	int           cyc;
	logic [255:0] corner [5];
	logic [255:0] op_a;
	logic [255:0] op_b;
	logic [255:0] last_r;

	//////////////////////////////////////////////////////////////////////
	// Clock, DUT and checker

	always #5 clk = ~clk;

	// Free-running cycle count for poll timeouts
	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	fe_mult_top UUT (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr)
	);

	fe_checker u_checker (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.psel_i     (psel),
		.penable_i  (penable),
		.pwrite_i   (pwrite),
		.paddr_i    (paddr),
		.prdata_i   (prdata),
		.pready_i   (pready),
		.pslverr_i  (pslverr),
		.exp_chk_i  (exp_chk),
		.exp_data_i (exp_data),
		.exp_err_i  (exp_err),
		.err_cnt_o  (chk_errs)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model

	// Full 512-bit product, then the remainder by p
	function automatic logic [255:0] mod_mul(input logic [255:0] x, input logic [255:0] y);
		logic [511:0] full;
		full = {256'd0, x} * {256'd0, y};
		full = full % {256'd0, P};
		return full[255:0];
	endfunction

	// Random element below p
	function automatic logic [255:0] rand_fe();
		logic [255:0] v;
		for (int i = 0; i < 8; i++) begin
			v[32*i +: 32] = $urandom;
		end
		v[255] = 1'b0;
		if (v >= P) begin
			v = v - P;
		end
		return v;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// APB driver

	// Setup cycle, access cycle, then idle
	task automatic bus_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			input logic chk, input logic [31:0] exp, input logic err,
			output logic [31:0] rdata);
		@(posedge clk);
		psel     <= 1'b1;
		penable  <= 1'b0;
		pwrite   <= wr;
		paddr    <= addr;
		pwdata   <= wdata;
		exp_chk  <= chk;
		exp_data <= exp;
		exp_err  <= err;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		rdata = prdata;
		psel    <= 1'b0;
		penable <= 1'b0;
		exp_chk <= 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic err);
		logic [31:0] unused;
		bus_xfer(1'b1, addr, data, 1'b0, 32'd0, err, unused);
	endtask

	// Read with the expected word handed to the checker
	task automatic expect_reg(input logic [7:0] addr, input logic [31:0] exp, input logic err);
		logic [31:0] unused;
		bus_xfer(1'b0, addr, 32'd0, 1'b1, exp, err, unused);
	endtask

	task automatic load_operands(input logic [255:0] a, input logic [255:0] b);
		for (int i = 0; i < 8; i++) begin
			write_reg(8'(`FE_ADDR_A + 4 * i), a[32*i +: 32], 1'b0);
			write_reg(8'(`FE_ADDR_B + 4 * i), b[32*i +: 32], 1'b0);
		end
	endtask

	// Poll STATUS until done is set
	task automatic wait_done();
		int start_cyc;
		logic [31:0] st;
		start_cyc = cyc;
		st = '0;
		while (!st[1] && (cyc - start_cyc) < POLL_LIMIT) begin
			bus_xfer(1'b0, `FE_ADDR_STATUS, 32'd0, 1'b0, 32'd0, 1'b0, st);
		end
		if (!st[1]) begin
			$display("Timeout at %0t: STATUS done bit not set within %0d cycles",
				$time, POLL_LIMIT);
			tmo_errs++;
		end
	endtask

	task automatic check_result(input logic [255:0] exp);
		for (int i = 0; i < 8; i++) begin
			expect_reg(8'(`FE_ADDR_R + 4 * i), exp[32*i +: 32], 1'b0);
		end
	endtask

	// Start must show busy with done cleared
	task automatic start_op();
		write_reg(`FE_ADDR_CTRL, 32'd1, 1'b0);
		expect_reg(`FE_ADDR_STATUS, 32'h1, 1'b0);
	endtask

	task automatic run_product(input logic [255:0] a, input logic [255:0] b);
		load_operands(a, b);
		start_op();
		wait_done();
		expect_reg(`FE_ADDR_STATUS, 32'h2, 1'b0);
		last_r = mod_mul(a, b);
		check_result(last_r);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		clk      = 1'b0;
		rst_n_i  = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		exp_chk  = 1'b0;
		exp_data = '0;
		exp_err  = 1'b0;
		cyc      = 0;
		tmo_errs = 0;
		void'($urandom(32'h48af3289));
		corner[0] = 256'd0;
		corner[1] = 256'd1;
		corner[2] = P - 256'd1;
		corner[3] = (256'd1 << 255) - 256'd20;
		corner[4] = 256'd19;

		repeat (16) @(posedge clk);
		rst_n_i <= 1'b1;

		// Idle after reset
		expect_reg(`FE_ADDR_STATUS, 32'h0, 1'b0);

		// Every pair of corner operands
		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 5; j++) begin
				run_product(corner[i], corner[j]);
			end
		end

		// Random operands below p
		repeat (200) begin
			run_product(rand_fe(), rand_fe());
		end

		// Writes while busy are refused
		op_a = rand_fe();
		op_b = rand_fe();
		load_operands(op_a, op_b);
		start_op();
		write_reg(`FE_ADDR_A, ~op_a[31:0], 1'b1);
		write_reg(8'(`FE_ADDR_B + 28), ~op_b[255:224], 1'b1);
		write_reg(`FE_ADDR_CTRL, 32'd1, 1'b1);
		wait_done();
		expect_reg(`FE_ADDR_STATUS, 32'h2, 1'b0);
		last_r = mod_mul(op_a, op_b);
		check_result(last_r);

		// Unmapped, unaligned and read-only targets
		write_reg(8'h48, 32'hdeadbeef, 1'b1);
		write_reg(8'h5c, 32'hdeadbeef, 1'b1);
		write_reg(8'h80, 32'hdeadbeef, 1'b1);
		write_reg(8'hfc, 32'hdeadbeef, 1'b1);
		write_reg(8'h02, 32'hdeadbeef, 1'b1);
		write_reg(`FE_ADDR_STATUS, 32'h0, 1'b1);
		write_reg(8'(`FE_ADDR_R + 4), 32'hdeadbeef, 1'b1);
		expect_reg(8'h48, 32'h0, 1'b1);
		expect_reg(8'h81, 32'h0, 1'b1);

		// Nothing above may have landed
		for (int i = 0; i < 8; i++) begin
			expect_reg(8'(`FE_ADDR_A + 4 * i), op_a[32*i +: 32], 1'b0);
			expect_reg(8'(`FE_ADDR_B + 4 * i), op_b[32*i +: 32], 1'b0);
		end
		expect_reg(`FE_ADDR_STATUS, 32'h2, 1'b0);
		check_result(last_r);

		// Second start after completion with fresh operands
		run_product(rand_fe(), rand_fe());

		repeat (2) @(posedge clk);
		$display("Closing counts: %0d check errors, %0d timeouts", chk_errs, tmo_errs);
		if (chk_errs == 0 && tmo_errs == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: verif/fe_checker.sv
`include "fe_consts.svh"

module fe_checker (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [7:0]  paddr_i,
	input  logic [31:0] prdata_i,
	input  logic        pready_i,
	input  logic        pslverr_i,
	input  logic        exp_chk_i,
	input  logic [31:0] exp_data_i,
	input  logic        exp_err_i,
	output int          err_cnt_o
);

	initial begin
		err_cnt_o = 0;
	end

	//////////////////////////////////////////////////////////////////////
	// Access phase compare

	// Samples at the edge that closes the access cycle
	// Bus values are the ones held through that cycle
	always @(posedge clk) begin
		int n;
		n = 0;
		if (rst_n_i && psel_i && penable_i) begin
			// No wait states on this slave
			if (pready_i !== 1'b1) begin
				$display("FAILED %0t pready expected 1 actual %b", $time, pready_i);
				n++;
			end
			// Error response on every transfer
			if (pslverr_i !== exp_err_i) begin
				$display("FAILED %0t pslverr addr %h write %b expected %b actual %b",
					$time, paddr_i, pwrite_i, exp_err_i, pslverr_i);
				n++;
			end
			// Read data only where the testbench armed a compare
			if (!pwrite_i && exp_chk_i && (prdata_i !== exp_data_i)) begin
				$display("FAILED %0t prdata addr %h expected %h actual %h",
					$time, paddr_i, exp_data_i, prdata_i);
				n++;
			end
		end
		err_cnt_o <= err_cnt_o + n;
	end

endmodule

// File: verilog/fe_mult_top.sv
`include "fe_consts.svh"

module fe_mult_top import fe_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [7:0]  paddr_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic        pready_o,
	output logic        pslverr_o
);

	// Operands and result
	fe_u a;
	fe_u b;
	fe_u b_rot;
	fe_u r;

	// Chain handshakes
	logic                 start;
	logic                 pass_en;
	logic [4:0]           pass_idx;
	logic                 pass_done;
	logic [`FE_SUM_W-1:0] pass_sum;
	logic                 red_done;

	//////////////////////////////////////////////////////////////////////
	// Bus side

	fe_apb_regs u_regs (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.psel_i     (psel_i),
		.penable_i  (penable_i),
		.pwrite_i   (pwrite_i),
		.paddr_i    (paddr_i),
		.pwdata_i   (pwdata_i),
		.prdata_o   (prdata_o),
		.pready_o   (pready_o),
		.pslverr_o  (pslverr_o),
		.a_o        (a),
		.b_o        (b),
		.start_o    (start),
		.done_i     (red_done),
		.r_i        (r)
	);

	//////////////////////////////////////////////////////////////////////
	// Multiplier chain

	// Sequencer launches one pass per output limb
	fe_mult_seq u_seq (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.start_i     (start),
		.b_i         (b),
		.pass_done_i (pass_done),
		.pass_en_o   (pass_en),
		.pass_idx_o  (pass_idx),
		.b_rot_o     (b_rot)
	);

	fe_mult_pass u_pass (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.en_i    (pass_en),
		.idx_i   (pass_idx),
		.a_i     (a),
		.b_rot_i (b_rot),
		.done_o  (pass_done),
		.sum_o   (pass_sum)
	);

	// Every pass result feeds the reducer directly
	fe_reduce u_reduce (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.start_i     (start),
		.sum_valid_i (pass_done),
		.sum_i       (pass_sum),
		.done_o      (red_done),
		.r_o         (r)
	);

endmodule

// File: verilog/fe_reduce.sv
`include "fe_consts.svh"

module fe_reduce import fe_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 start_i,
	input  logic                 sum_valid_i,
	input  logic [`FE_SUM_W-1:0] sum_i,
	output logic                 done_o,
	output fe_u                  r_o
);

	// FSM encoding
	localparam logic [2:0] ST_IDLE    = 3'd0;
	localparam logic [2:0] ST_COLLECT = 3'd1;
	localparam logic [2:0] ST_CARRY1  = 3'd2;
	localparam logic [2:0] ST_CARRY2  = 3'd3;
	localparam logic [2:0] ST_SUB     = 3'd4;

	localparam logic [4:0] LAST_LIMB = 5'(`FE_NLIMBS - 1);

	// The field prime 2^255 - 19
	localparam logic [255:0] P_MOD = (256'd1 << 255) - 256'd19;

	logic [2:0]           state;
	logic [4:0]           limb_idx;
	logic [`FE_SUM_W-1:0] sums [`FE_NLIMBS];
	logic [`FE_SUM_W-1:0] carry;
	logic [`FE_SUM_W-1:0] t;
	logic [256:0]         diff;

	// Limb plus incoming carry
	assign t = sums[limb_idx] + carry;

	// Top bit set means a borrow, so the value is already below p
	assign diff = {1'b0, r_o.flat} - {1'b0, P_MOD};

	//////////////////////////////////////////////////////////////////////
	// FSM

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state    <= ST_IDLE;
			limb_idx <= '0;
			done_o   <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				ST_COLLECT: begin
					// Sums arrive in limb order
					if (sum_valid_i) begin
						limb_idx <= limb_idx + 5'd1;
						if (limb_idx == LAST_LIMB) begin
							state <= ST_CARRY1;
						end
					end
				end
				ST_CARRY1: begin
					limb_idx <= limb_idx + 5'd1;
					if (limb_idx == LAST_LIMB) begin
						state <= ST_CARRY2;
					end
				end
				ST_CARRY2: begin
					limb_idx <= limb_idx + 5'd1;
					if (limb_idx == LAST_LIMB) begin
						state <= ST_SUB;
					end
				end
				ST_SUB: begin
					// Stay until the value drops below p
					if (diff[256]) begin
						state  <= ST_IDLE;
						done_o <= 1'b1;
					end
				end
				default: ;
			endcase
			// New operation restarts collection
			if (start_i) begin
				state    <= ST_COLLECT;
				limb_idx <= '0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Datapath

	always_ff @(posedge clk) begin
		case (state)
			ST_COLLECT: begin
				if (sum_valid_i) begin
					sums[limb_idx] <= sum_i;
					// Round 1 starts with no carry
					carry <= '0;
				end
			end
			ST_CARRY1: begin
				if (limb_idx == LAST_LIMB) begin
					// Limb 31 keeps bits below 2^255
					// Everything from bit 7 up comes back into limb 0 times 19
					sums[limb_idx] <= `FE_SUM_W'(t[`FE_LIMB_W-2:0]);
					carry <= (t >> (`FE_LIMB_W - 1)) * `FE_FOLD_MUL;
				end else begin
					sums[limb_idx] <= `FE_SUM_W'(t[`FE_LIMB_W-1:0]);
					carry <= t >> `FE_LIMB_W;
				end
			end
			ST_CARRY2: begin
				// Carries are tiny by now
				// Limb 31 ends at most 128, so the value stays below 2p
				r_o.limbs[limb_idx] <= t[`FE_LIMB_W-1:0];
				carry <= t >> `FE_LIMB_W;
			end
			ST_SUB: begin
				if (!diff[256]) begin
					r_o.flat <= diff[255:0];
				end
			end
			default: ;
		endcase
	end

endmodule

// File: verilog/fe_mult_pass.sv
`include "fe_consts.svh"

module fe_mult_pass import fe_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 en_i,
	input  logic [4:0]           idx_i,
	input  fe_u                  a_i,
	input  fe_u                  b_rot_i,
	output logic                 done_o,
	output logic [`FE_SUM_W-1:0] sum_o
);

	// Limb groups per pass, one per cycle
	localparam int GROUPS = `FE_NLIMBS / `FE_PRODS_PER_CYC;
	localparam int CNT_W  = $clog2(GROUPS);
	localparam logic [CNT_W-1:0] LAST_GRP = CNT_W'(GROUPS - 1);

	logic                 busy;
	logic [CNT_W-1:0]     grp_cnt;
	logic [`FE_SUM_W-1:0] grp_sum;
	logic [`FE_SUM_W-1:0] acc;

	//////////////////////////////////////////////////////////////////////
	// Product group

	// Counter rests at zero while idle
	// So group 0 is summed in the enable cycle itself
	always_comb begin
		int j;
		logic [`FE_SUM_W-1:0] prod;
		grp_sum = '0;
		for (int m = 0; m < `FE_PRODS_PER_CYC; m++) begin
			j = int'(grp_cnt) * `FE_PRODS_PER_CYC + m;
			prod = `FE_SUM_W'(a_i.limbs[j]) * `FE_SUM_W'(b_rot_i.limbs[j]);
			// Limb pairs above the output index wrapped past 2^256
			if (j > int'(idx_i)) begin
				prod = prod * `FE_WRAP_MUL;
			end
			grp_sum = grp_sum + prod;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Group counter

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy    <= 1'b0;
			grp_cnt <= '0;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (en_i) begin
				busy    <= 1'b1;
				grp_cnt <= CNT_W'(1);
			end else if (busy) begin
				if (grp_cnt == LAST_GRP) begin
					// Sum leaves eight cycles after enable
					busy    <= 1'b0;
					grp_cnt <= '0;
					done_o  <= 1'b1;
				end else begin
					grp_cnt <= grp_cnt + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Accumulator

	always_ff @(posedge clk) begin
		if (en_i) begin
			acc <= grp_sum;
		end else if (busy) begin
			acc <= acc + grp_sum;
			if (grp_cnt == LAST_GRP) begin
				sum_o <= acc + grp_sum;
			end
		end
	end

endmodule

// File: verilog/fe_mult_seq.sv
`include "fe_consts.svh"

module fe_mult_seq import fe_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       start_i,
	input  fe_u        b_i,
	input  logic       pass_done_i,
	output logic       pass_en_o,
	output logic [4:0] pass_idx_o,
	output fe_u        b_rot_o
);

	// Index of the final pass
	localparam logic [4:0] LAST_PASS = 5'(`FE_NLIMBS - 1);

	fe_u  b_first;
	fe_u  b_next;
	logic advance;

	//////////////////////////////////////////////////////////////////////
	// B limb arrangement

	// Pass 0 pairs A limb j with B limb (0 - j) mod 32
	// So limb 0 stays and the rest are reversed
	always_comb begin
		b_first.limbs[0] = b_i.limbs[0];
		for (int i = 1; i < `FE_NLIMBS; i++) begin
			b_first.limbs[i] = b_i.limbs[`FE_NLIMBS - i];
		end
	end

	// Each later pass shifts every limb up one place
	// Top limb wraps to the bottom
	always_comb begin
		b_next.limbs[0] = b_rot_o.limbs[`FE_NLIMBS - 1];
		for (int i = 1; i < `FE_NLIMBS; i++) begin
			b_next.limbs[i] = b_rot_o.limbs[i - 1];
		end
	end

	// Another pass follows unless the last one just ended
	assign advance = pass_done_i && (pass_idx_o != LAST_PASS);

	//////////////////////////////////////////////////////////////////////
	// Pass control

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pass_en_o  <= 1'b0;
			pass_idx_o <= '0;
		end else begin
			// Launch one cycle after start or after a pass completes
			pass_en_o <= start_i | advance;
			if (start_i) begin
				pass_idx_o <= '0;
			end else if (advance) begin
				pass_idx_o <= pass_idx_o + 5'd1;
			end
		end
	end

	// Rotated operand held steady for the whole pass
	always_ff @(posedge clk) begin
		if (start_i) begin
			b_rot_o <= b_first;
		end else if (advance) begin
			b_rot_o <= b_next;
		end
	end

endmodule

// File: verilog/fe_apb_regs.sv
`include "fe_consts.svh"

module fe_apb_regs import fe_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,

	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [7:0]  paddr_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic        pready_o,
	output logic        pslverr_o,

	output fe_u         a_o,
	output fe_u         b_o,
	output logic        start_o,

	input  logic        done_i,
	input  fe_u         r_i
);

	// Base addresses as sliceable values
	localparam logic [7:0] ADDR_A      = `FE_ADDR_A;
	localparam logic [7:0] ADDR_B      = `FE_ADDR_B;
	localparam logic [7:0] ADDR_CTRL   = `FE_ADDR_CTRL;
	localparam logic [7:0] ADDR_STATUS = `FE_ADDR_STATUS;
	localparam logic [7:0] ADDR_R      = `FE_ADDR_R;

	logic       access;
	logic       aligned;
	logic [7:0] bit_base;
	logic       hit_a;
	logic       hit_b;
	logic       hit_ctrl;
	logic       hit_status;
	logic       hit_r;
	logic       mapped;
	logic       wr_err;
	logic       wr_ok;
	logic       start_req;
	logic       busy_q;
	logic       done_q;

	//////////////////////////////////////////////////////////////////////
	// Address decode

	// Access phase of an APB transfer
	assign access = psel_i & penable_i;

	// Only whole words are mapped
	assign aligned = (paddr_i[1:0] == 2'b00);

	// First bit of the selected 32-bit word in a 256-bit window
	assign bit_base = {paddr_i[4:2], 5'd0};

	// Eight-word windows match on the top three address bits
	assign hit_a      = aligned && (paddr_i[7:5] == ADDR_A[7:5]);
	assign hit_b      = aligned && (paddr_i[7:5] == ADDR_B[7:5]);
	assign hit_r      = aligned && (paddr_i[7:5] == ADDR_R[7:5]);
	assign hit_ctrl   = (paddr_i == ADDR_CTRL);
	assign hit_status = (paddr_i == ADDR_STATUS);

	assign mapped = hit_a | hit_b | hit_ctrl | hit_status | hit_r;

	//////////////////////////////////////////////////////////////////////
	// Error response

	// STATUS and R are read only
	// Operands and CTRL are locked while a product is in flight
	assign wr_err = !mapped | hit_status | hit_r
		| (busy_q & (hit_a | hit_b | hit_ctrl));

	// Reads fail only on unmapped addresses
	assign pslverr_o = access & (pwrite_i ? wr_err : !mapped);

	// No wait states
	assign pready_o = 1'b1;

	// Writes that land
	assign wr_ok = access & pwrite_i & !wr_err;

	// CTRL bit 0 written as one while idle
	assign start_req = wr_ok & hit_ctrl & pwdata_i[0];

	//////////////////////////////////////////////////////////////////////
	// Operand storage

	// Word writes into the flat view of each operand
	always_ff @(posedge clk) begin
		if (wr_ok && hit_a) begin
			a_o.flat[bit_base +: 32] <= pwdata_i;
		end
		if (wr_ok && hit_b) begin
			b_o.flat[bit_base +: 32] <= pwdata_i;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Start pulse and status flags

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			start_o <= 1'b0;
			busy_q  <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			// One-cycle pulse into the sequencer and reducer
			start_o <= start_req;
			if (start_req) begin
				busy_q <= 1'b1;
				done_q <= 1'b0;
			end else if (done_i) begin
				// Reducer finished
				busy_q <= 1'b0;
				done_q <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read mux

	always_comb begin
		prdata_o = '0;
		if (hit_a) begin
			prdata_o = a_o.flat[bit_base +: 32];
		end else if (hit_b) begin
			prdata_o = b_o.flat[bit_base +: 32];
		end else if (hit_status) begin
			// Bit 1 done, bit 0 busy
			prdata_o = {30'd0, done_q, busy_q};
		end else if (hit_r) begin
			prdata_o = r_i.flat[bit_base +: 32];
		end
		// CTRL reads back as zero
	end

endmodule

// File: verilog/fe_pkg.sv
`include "fe_consts.svh"

package fe_pkg;

	//////////////////////////////////////////////////////////////////////
	// Field element word

	// One 256-bit element mod 2^255-19
	// The register file slices it as a flat integer
	// The multiplier chain walks it limb by limb
	typedef union packed {
		// Flat view for 32-bit bus words
		logic [`FE_NLIMBS*`FE_LIMB_W-1:0] flat;
		// Byte limbs, limb 0 is least significant
		logic [`FE_NLIMBS-1:0][`FE_LIMB_W-1:0] limbs;
	} fe_u;

endpackage

// File: verilog/fe_consts.svh
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Field element geometry

// Limbs per element and bits per limb
`define FE_NLIMBS 32
`define FE_LIMB_W 8

// Width of one accumulated output limb from the pass unit
`define FE_SUM_W 32

// Limb products summed in each pass cycle
`define FE_PRODS_PER_CYC 4

//////////////////////////////////////////////////////////////////////
// APB byte addresses

`define FE_ADDR_A 8'h00
`define FE_ADDR_B 8'h20
`define FE_ADDR_CTRL 8'h40
`define FE_ADDR_STATUS 8'h44
`define FE_ADDR_R 8'h60

//////////////////////////////////////////////////////////////////////
// Reduction weights

// 2^256 mod p for products that wrap past the top limb
`define FE_WRAP_MUL 38
// 2^255 mod p for bits folded down from the top limb
`define FE_FOLD_MUL 19

`endif
